//--- accel_pkg.sv
`default_nettype none

package accel_pkg;

    // host address width, covers the RAM and the tile ports
    parameter int addr_w = 9;

    // one signed lane of a vector word
    parameter int lane_w = 16;

    parameter int ram_depth = 256;

    // tiles per kind, fixed by the two unit bits of the address map
    parameter int n_tiles = 4;

    // group codes, X and Y of one kind share a group and differ in is_y
    parameter logic [3:0] grp_acc_x  = 4'h0;
    parameter logic [3:0] grp_acc_y  = 4'h0;
    parameter logic [3:0] grp_norm_x = 4'h1;
    parameter logic [3:0] grp_norm_y = 4'h1;

    // one host address, seen either as a RAM index or as a tile port
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic       is_mmio;
            logic [3:0] group;
            logic       is_y;
            logic       spare;
            logic [1:0] unit;
        } mmio;
    } rf_addr_u;

endpackage

`default_nettype wire

//--- bram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bram_if #(
    parameter int data_w = 64
) ();

    logic [$clog2(accel_pkg::ram_depth)-1:0] addr;
    logic                                    we;
    logic                                    re;
    logic [data_w-1:0]                       d;
    logic [data_w-1:0]                       q;

    // decoder side
    modport ctrl (output addr, output we, output re, output d, input q);

    // memory side
    modport mem (input addr, input we, input re, input d, output q);

endinterface

`default_nettype wire

//--- vec_bram.sv
`timescale 1ns/1ps
`default_nettype none

module vec_bram (
    input logic clk,
    bram_if.mem mem
);

    // inferred block RAM, one entry per vector word
    logic [$bits(mem.d)-1:0] store [accel_pkg::ram_depth];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            store[mem.addr] <= mem.d;
        end
    end

    // q is registered and holds its value while re is low
    always_ff @(posedge clk) begin
        if (mem.re) begin
            mem.q <= store[mem.addr];
        end
    end

endmodule

`default_nettype wire

//--- rf_ram.sv
`timescale 1ns/1ps
`default_nettype none

module rf_ram #(
    parameter int data_w = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // host strobes
    input  logic [accel_pkg::addr_w-1:0]  rf_addr,
    input  logic                          rf_we,
    input  logic                          rf_re,
    input  logic [data_w-1:0]             rf_d,
    output logic [data_w-1:0]             rf_q,

    bram_if.ctrl                          ram,

    // accumulate tiles
    output logic [data_w-1:0]             acc_x_data,
    output logic [accel_pkg::n_tiles-1:0] acc_x_ld,
    input  logic [data_w-1:0]             acc_y_data [accel_pkg::n_tiles],

    // normalize tiles
    output logic [data_w-1:0]             norm_x_data,
    output logic [accel_pkg::n_tiles-1:0] norm_x_ld,
    input  logic [data_w-1:0]             norm_y_data [accel_pkg::n_tiles]
);

    // all ones decodes to group 0xf, which maps nothing
    localparam logic [accel_pkg::addr_w-1:0] idle_addr = '1;

    accel_pkg::rf_addr_u cur_addr;
    accel_pkg::rf_addr_u rd_addr;

    assign cur_addr.raw = rf_addr;

    // write data fans out to every target, the strobes pick the one that takes it
    assign acc_x_data  = rf_d;
    assign norm_x_data = rf_d;
    assign ram.d       = rf_d;
    assign ram.addr    = cur_addr.raw[$bits(ram.addr)-1:0];

    // ram reads only for addresses below the mmio window
    assign ram.re = rf_re && !cur_addr.mmio.is_mmio;

    // write routing: RAM, one tile load, or dropped when unmapped
    always_comb begin
        ram.we    = 1'b0;
        acc_x_ld  = '0;
        norm_x_ld = '0;
        if (!cur_addr.mmio.is_mmio) begin
            ram.we = rf_we;
        end else if (rf_we && !cur_addr.mmio.is_y && !cur_addr.mmio.spare) begin
            if (cur_addr.mmio.group == accel_pkg::grp_acc_x) begin
                acc_x_ld[cur_addr.mmio.unit] = 1'b1;
            end else if (cur_addr.mmio.group == accel_pkg::grp_norm_x) begin
                norm_x_ld[cur_addr.mmio.unit] = 1'b1;
            end
        end
    end

    // read address lines up with the RAM output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_addr.raw <= idle_addr;
        end else if (rf_re) begin
            rd_addr <= cur_addr;
        end
    end

    // read-back select
    always_comb begin
        rf_q = '0;
        if (!rd_addr.mmio.is_mmio) begin
            rf_q = ram.q;
        end else if (rd_addr.mmio.is_y && !rd_addr.mmio.spare) begin
            if (rd_addr.mmio.group == accel_pkg::grp_acc_y) begin
                rf_q = acc_y_data[rd_addr.mmio.unit];
            end else if (rd_addr.mmio.group == accel_pkg::grp_norm_y) begin
                rf_q = norm_y_data[rd_addr.mmio.unit];
            end
        end
    end

    // host must not strobe a write and a read together
    a_host_we_re_excl : assert property (
        @(posedge clk) disable iff (!rst_n) !(rf_we && rf_re)
    );

    // at most one tile of either kind loads per cycle
    a_single_load : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({acc_x_ld, norm_x_ld})
    );

endmodule

`default_nettype wire

//--- acc_tile.sv
`timescale 1ns/1ps
`default_nettype none

module acc_tile #(
    parameter int data_w = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] x_data,
    input  logic              x_ld,
    output logic [data_w-1:0] y_data
);

    localparam int lw      = accel_pkg::lane_w;
    localparam int n_lanes = data_w / lw;

    localparam logic [lw-1:0] lane_max = {1'b0, {(lw-1){1'b1}}};
    localparam logic [lw-1:0] lane_min = {1'b1, {(lw-1){1'b0}}};

    logic [data_w-1:0] acc;
    logic [data_w-1:0] acc_next;

    if (data_w % lw != 0) begin : g_bad_width
        $error("acc_tile: data_w must be a multiple of the lane width");
    end

    // one extra bit per lane catches the overflow
    always_comb begin
        logic signed [lw:0] sum;
        for (int i = 0; i < n_lanes; i++) begin
            sum = signed'(acc[i*lw +: lw]) + signed'(x_data[i*lw +: lw]);
            if (sum[lw] != sum[lw-1]) begin
                acc_next[i*lw +: lw] = sum[lw] ? lane_min : lane_max;
            end else begin
                acc_next[i*lw +: lw] = sum[lw-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (x_ld) begin
            acc <= acc_next;
        end
    end

    assign y_data = acc;

    a_load_known : assert property (
        @(posedge clk) disable iff (!rst_n) x_ld |-> !$isunknown(x_data)
    );

endmodule

`default_nettype wire

//--- norm_tile.sv
`timescale 1ns/1ps
`default_nettype none

module norm_tile #(
    parameter int data_w = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] x_data,
    input  logic              x_ld,
    output logic [data_w-1:0] y_data
);

    localparam int lw      = accel_pkg::lane_w;
    localparam int n_lanes = data_w / lw;
    localparam int sh      = $clog2(n_lanes);

    // sum of all lanes needs sh growth bits
    localparam int sw = lw + sh;

    logic [data_w-1:0] held;
    logic [data_w-1:0] held_next;

    // mean is a shift, so the lane count has to be a power of two
    if ((n_lanes & (n_lanes - 1)) != 0 || n_lanes * lw != data_w) begin : g_bad_lanes
        $error("norm_tile: data_w must hold a power-of-two number of lanes");
    end

    always_comb begin
        logic signed [sw-1:0] sum;
        logic signed [sw-1:0] mean;
        logic signed [sw-1:0] diff;
        sum = '0;
        for (int i = 0; i < n_lanes; i++) begin
            sum = sum + signed'(x_data[i*lw +: lw]);
        end
        // arithmetic shift, so the mean rounds toward minus infinity
        mean = sum >>> sh;
        for (int i = 0; i < n_lanes; i++) begin
            diff = signed'(x_data[i*lw +: lw]) - mean;
            held_next[i*lw +: lw] = diff[lw-1:0];
        end
    end

    // a new load replaces the previous word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= '0;
        end else if (x_ld) begin
            held <= held_next;
        end
    end

    assign y_data = held;

endmodule

`default_nettype wire

//--- rf_top.sv
`timescale 1ns/1ps
`default_nettype none

module rf_top #(
    parameter int data_w = 64
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [accel_pkg::addr_w-1:0] rf_addr,
    input  logic                         rf_we,
    input  logic                         rf_re,
    input  logic [data_w-1:0]            rf_d,
    output logic [data_w-1:0]            rf_q
);

    logic [data_w-1:0]             acc_x_data;
    logic [accel_pkg::n_tiles-1:0] acc_x_ld;
    logic [data_w-1:0]             acc_y_data [accel_pkg::n_tiles];

    logic [data_w-1:0]             norm_x_data;
    logic [accel_pkg::n_tiles-1:0] norm_x_ld;
    logic [data_w-1:0]             norm_y_data [accel_pkg::n_tiles];

    bram_if #(.data_w(data_w)) ram_bus ();

    rf_ram #(.data_w(data_w)) u_rf_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .rf_addr     (rf_addr),
        .rf_we       (rf_we),
        .rf_re       (rf_re),
        .rf_d        (rf_d),
        .rf_q        (rf_q),
        .ram         (ram_bus.ctrl),
        .acc_x_data  (acc_x_data),
        .acc_x_ld    (acc_x_ld),
        .acc_y_data  (acc_y_data),
        .norm_x_data (norm_x_data),
        .norm_x_ld   (norm_x_ld),
        .norm_y_data (norm_y_data)
    );

    vec_bram u_vec_bram (
        .clk (clk),
        .mem (ram_bus.mem)
    );

    for (genvar i = 0; i < accel_pkg::n_tiles; i++) begin : g_tiles
        acc_tile #(.data_w(data_w)) u_acc_tile (
            .clk    (clk),
            .rst_n  (rst_n),
            .x_data (acc_x_data),
            .x_ld   (acc_x_ld[i]),
            .y_data (acc_y_data[i])
        );

        norm_tile #(.data_w(data_w)) u_norm_tile (
            .clk    (clk),
            .rst_n  (rst_n),
            .x_data (norm_x_data),
            .x_ld   (norm_x_ld[i]),
            .y_data (norm_y_data[i])
        );
    end

endmodule

`default_nettype wire

//--- rf_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rf_checker #(
    parameter int data_w = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rf_re,
    input  logic              chk,
    input  logic [data_w-1:0] exp_q,
    input  logic [data_w-1:0] rf_q,
    output int                checks,
    output int                errors,
    output logic              busy
);

    logic [data_w-1:0] pend_exp;

    // strobes change just after the rising edge, so the falling edge sees them settled
    // and rf_q of the previous read is stable there too
    always @(negedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            checks   <= 0;
            errors   <= 0;
            pend_exp <= '0;
        end else begin
            // read strobed half a cycle before the last rising edge
            if (busy) begin
                checks <= checks + 1;
                if (rf_q !== pend_exp) begin
                    errors <= errors + 1;
                    $display("ERROR %0t rf_q expected %h actual %h",
                             $time, pend_exp, rf_q);
                end
            end
            busy     <= rf_re && chk;
            pend_exp <= exp_q;
        end
    end

endmodule

`default_nettype wire

//--- tb_rf_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rf_top;

    localparam int data_w  = 64;
    localparam int lw      = accel_pkg::lane_w;
    localparam int n_lanes = data_w / lw;

    typedef struct packed {
        logic                         we;
        logic                         re;
        logic [accel_pkg::addr_w-1:0] addr;
        logic [data_w-1:0]            data;
        logic [data_w-1:0]            exp;
        logic                         chk;
    } row_t;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic [accel_pkg::addr_w-1:0] rf_addr;
    logic                         rf_we;
    logic                         rf_re;
    logic [data_w-1:0]            rf_d;
    logic [data_w-1:0]            rf_q;
    logic [data_w-1:0]            exp_q;
    logic                         chk;
    int                           checks;
    int                           errors;
    logic                         busy;

    row_t              rows[$];
    int                n_checks;
    logic [31:0]       lfsr = 32'h54f94523;
    logic [data_w-1:0] ram_m [256];
    logic [data_w-1:0] acc_m [accel_pkg::n_tiles];
    logic [data_w-1:0] norm_m [accel_pkg::n_tiles];

    always #10 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    rf_top #(.data_w(data_w)) u_rf_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .rf_addr (rf_addr),
        .rf_we   (rf_we),
        .rf_re   (rf_re),
        .rf_d    (rf_d),
        .rf_q    (rf_q)
    );

    rf_checker #(.data_w(data_w)) u_rf_checker (
        .clk    (clk),
        .rst_n  (rst_n),
        .rf_re  (rf_re),
        .chk    (chk),
        .exp_q  (exp_q),
        .rf_q   (rf_q),
        .checks (checks),
        .errors (errors),
        .busy   (busy)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_word(output logic [data_w-1:0] w);
        for (int i = 0; i < data_w; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[data_w-2:0], lfsr[0]};
        end
    endtask

    function automatic logic [data_w-1:0] sat_sum(input logic [data_w-1:0] a,
                                                  input logic [data_w-1:0] b);
        logic [data_w-1:0] r;
        int s;
        for (int i = 0; i < n_lanes; i++) begin
            s = int'($signed(a[i*lw +: lw])) + int'($signed(b[i*lw +: lw]));
            if (s > (1 << (lw - 1)) - 1) s = (1 << (lw - 1)) - 1;
            else if (s < -(1 << (lw - 1))) s = -(1 << (lw - 1));
            r[i*lw +: lw] = s[lw-1:0];
        end
        return r;
    endfunction

    // each lane minus the mean, mean rounded toward minus infinity
    function automatic logic [data_w-1:0] lane_norm(input logic [data_w-1:0] x);
        logic [data_w-1:0] r;
        int sum;
        int mean;
        int d;
        sum = 0;
        for (int i = 0; i < n_lanes; i++) sum += int'($signed(x[i*lw +: lw]));
        mean = sum / n_lanes;
        if (sum < 0 && sum % n_lanes != 0) mean = mean - 1;
        for (int i = 0; i < n_lanes; i++) begin
            d = int'($signed(x[i*lw +: lw])) - mean;
            r[i*lw +: lw] = d[lw-1:0];
        end
        return r;
    endfunction

    task automatic wr(input logic [accel_pkg::addr_w-1:0] addr, input logic [data_w-1:0] data);
        accel_pkg::rf_addr_u a;
        a.raw = addr;
        if (!a.mmio.is_mmio) begin
            ram_m[a.raw[7:0]] = data;
        end else if (!a.mmio.is_y && !a.mmio.spare) begin
            if (a.mmio.group == accel_pkg::grp_acc_x)
                acc_m[a.mmio.unit] = sat_sum(acc_m[a.mmio.unit], data);
            else if (a.mmio.group == accel_pkg::grp_norm_x)
                norm_m[a.mmio.unit] = lane_norm(data);
        end
        rows.push_back('{1'b1, 1'b0, addr, data, '0, 1'b0});
    endtask

    task automatic rd(input logic [accel_pkg::addr_w-1:0] addr);
        accel_pkg::rf_addr_u a;
        logic [data_w-1:0] e;
        a.raw = addr;
        e = '0;
        if (!a.mmio.is_mmio) begin
            e = ram_m[a.raw[7:0]];
        end else if (a.mmio.is_y && !a.mmio.spare) begin
            if (a.mmio.group == accel_pkg::grp_acc_y) e = acc_m[a.mmio.unit];
            else if (a.mmio.group == accel_pkg::grp_norm_y) e = norm_m[a.mmio.unit];
        end
        rows.push_back('{1'b0, 1'b1, addr, '0, e, 1'b1});
        n_checks++;
    endtask

    initial begin
        logic [data_w-1:0]            w;
        logic [accel_pkg::addr_w-1:0] ram_addrs [5];
        int                           wait_cnt;
        bit                           timed_out;
        rf_addr   = '0;
        rf_we     = 1'b0;
        rf_re     = 1'b0;
        rf_d      = '0;
        exp_q     = '0;
        chk       = 1'b0;
        n_checks  = 0;
        timed_out = 1'b0;
        ram_addrs = '{9'h000, 9'h0ff, 9'h005, 9'h042, 9'h080};
        for (int i = 0; i < accel_pkg::n_tiles; i++) begin
            acc_m[i]  = '0;
            norm_m[i] = '0;
        end

        // tile results and unmapped reads right after reset
        rd(9'h108); rd(9'h10b); rd(9'h118); rd(9'h11b); rd(9'h1f0);
        foreach (ram_addrs[i]) begin
            next_word(w);
            wr(ram_addrs[i], w);
        end
        foreach (ram_addrs[i]) rd(ram_addrs[i]);
        next_word(w); wr(9'h100, w);
        next_word(w); wr(9'h100, w);
        rd(9'h108);
        // lanes pushed past both signed limits
        wr(9'h101, 64'h7ff0_8010_7ff0_8010);
        wr(9'h101, 64'h7ff0_8010_0020_ffe0);
        rd(9'h109);
        next_word(w); wr(9'h102, w);
        rd(9'h108); rd(9'h10a);
        next_word(w); wr(9'h110, w); rd(9'h118);
        next_word(w); wr(9'h110, w); rd(9'h118);
        // negative lane sum, so the floor differs from truncation
        wr(9'h113, 64'hfff9_0003_0002_0001); rd(9'h11b);
        next_word(w); wr(9'h100, w);
        rd(9'h000); rd(9'h108);
        next_word(w);
        wr(9'h1ff, w); wr(9'h104, w); wr(9'h142, w); wr(9'h1f0, w);
        rd(9'h0ff); rd(9'h042); rd(9'h108); rd(9'h118); rd(9'h1f0);

        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            foreach (rows[i]) begin
                @(posedge clk);
                #1;
                rf_we   = rows[i].we;
                rf_re   = rows[i].re;
                rf_addr = rows[i].addr;
                rf_d    = rows[i].data;
                exp_q   = rows[i].exp;
                chk     = rows[i].chk;
            end
            @(posedge clk);
            #1;
            rf_we = 1'b0;
            rf_re = 1'b0;
            chk   = 1'b0;
            wait_cnt = 0;
            while (busy !== 1'b0 && wait_cnt < 10) begin
                @(posedge clk);
                wait_cnt++;
            end
            if (busy !== 1'b0) begin
                $display("timeout: the last read-back was never compared");
                timed_out = 1'b1;
            end
        end

        if (!timed_out && checks != n_checks)
            $display("only %0d of %0d reads were compared", checks, n_checks);
        $display("checks %0d errors %0d", checks, errors);
        if (!timed_out && errors == 0 && checks == n_checks) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
accel_pkg.sv
bram_if.sv
vec_bram.sv
rf_ram.sv
acc_tile.sv
norm_tile.sv
rf_top.sv
rf_checker.sv
tb_rf_top.sv

//--- Bender.yml
package:
  name: rf_top

sources:
  - accel_pkg.sv
  - bram_if.sv
  - vec_bram.sv
  - rf_ram.sv
  - acc_tile.sv
  - norm_tile.sv
  - rf_top.sv
  - target: test
    files:
      - rf_checker.sv
      - tb_rf_top.sv
